// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module cpu_tb -f src.f -o cpu_sim

sim_output=$(./obj_dir/cpu_sim)
echo "$sim_output"

if grep -qx "TEST PASS" <<< "$sim_output"; then
  exit 0
fi
exit 1

// ==== src.f ====
verilog/cpu_pkg.sv
verilog/gpr.sv
verilog/ifu.sv
verilog/idu.sv
verilog/exu.sv
verilog/wbu.sv
verilog/mem_arb.sv
verilog/cpu.sv
tests/clock_gen.sv
tests/cpu_tb.sv

// ==== tests/clock_gen.sv ====
`default_nettype none

module clock_gen (
  input  wire  restart,
  output logic clock,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  // Cycles of reset still to run
  int hold = 16;

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
  end

  always @(posedge clock) begin
    if (restart) begin
      hold <= 16;
    end else if (hold > 0) begin
      hold <= hold - 1;
    end
  end

  // Reset changes on the falling edge like every other DUT input
  always @(negedge clock) begin
    reset <= (hold != 0);
  end

endmodule

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`default_nettype none

module cpu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int prog_len = 48;
  localparam int mem_words = 2048;

  logic clock, reset, restart;
  logic wb_cyc, wb_stb, wb_we, wb_ack;
  logic [3:0] wb_sel;
  cpu_pkg::word_t wb_adr, wb_dat_w, wb_dat_r;
  logic retire_valid, halted;
  cpu_pkg::word_t retire_pc, retire_data;
  cpu_pkg::reg_addr_t retire_rd;

  cpu_pkg::word_t image [mem_words];
  cpu_pkg::word_t mem [mem_words];
  cpu_pkg::word_t ref_mem [mem_words];

  // Expected retirements and bus writes, in program order
  cpu_pkg::word_t exp_pc [$];
  cpu_pkg::reg_addr_t exp_rd [$];
  cpu_pkg::word_t exp_data [$];
  cpu_pkg::word_t exp_st_adr [$];
  cpu_pkg::word_t exp_st_dat [$];

  int value_errors = 0;
  int other_errors = 0;
  int cycles = 0;
  int cycle_limit = 0;
  int retired, stores_seen, wait_left;
  logic zero_wait, bus_busy, pass_active, seen_halt;

  clock_gen clock_gen0 (.restart(restart), .clock(clock), .reset(reset));

  cpu dut0 (
    .clock(clock), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_sel(wb_sel),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_data(retire_data), .halted(halted)
  );

  task automatic check_word(input cpu_pkg::word_t got, input cpu_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(input cpu_pkg::reg_addr_t got, input cpu_pkg::reg_addr_t exp,
                           input string what);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  function automatic cpu_pkg::word_t r_type(logic [6:0] f7, cpu_pkg::reg_addr_t rs2,
      cpu_pkg::reg_addr_t rs1, logic [2:0] f3, cpu_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, cpu_pkg::opcode_op};
  endfunction

  function automatic cpu_pkg::word_t i_type(logic [11:0] imm, cpu_pkg::reg_addr_t rs1,
      logic [2:0] f3, cpu_pkg::reg_addr_t rd, logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic cpu_pkg::word_t s_type(logic [11:0] imm, cpu_pkg::reg_addr_t rs2,
      cpu_pkg::reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::opcode_store};
  endfunction

  function automatic cpu_pkg::word_t b_type(logic [12:0] imm, cpu_pkg::reg_addr_t rs2,
      cpu_pkg::reg_addr_t rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::opcode_branch};
  endfunction

  function automatic cpu_pkg::word_t u_type(logic [19:0] imm, cpu_pkg::reg_addr_t rd);
    return {imm, rd, cpu_pkg::opcode_lui};
  endfunction

  function automatic cpu_pkg::word_t j_type(logic [20:0] imm, cpu_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::opcode_jal};
  endfunction

  // x1 holds the data base 0x1000 and is never overwritten
  task automatic make_program();
    int kind, skip, room, k, sel;
    cpu_pkg::reg_addr_t rd, rs1, rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    for (int i = 0; i < mem_words; i++) begin
      image[i] = cpu_pkg::word_t'(i) * 32'h9e37_79b9 + 32'h0137_c0de;
    end
    image[0] = u_type(20'h00001, 5'd1);
    for (int i = 1; i < prog_len - 1; i++) begin
      kind = $urandom_range(0, 8);
      rd = 5'($urandom_range(0, 6));
      if (rd == 5'd1) begin
        rd = 5'd7;
      end
      rs1 = 5'($urandom_range(0, 7));
      rs2 = 5'($urandom_range(0, 7));
      room = prog_len - 1 - i;
      skip = $urandom_range(1, room > 3 ? 3 : room);
      k = $urandom_range(0, 63);
      sel = $urandom_range(0, 5);
      f3 = 3'b000;
      f7 = 7'b0000000;
      case (sel)
        1: f7 = 7'b0100000;
        2: f3 = 3'b010;
        3: f3 = 3'b100;
        4: f3 = 3'b110;
        5: f3 = 3'b111;
        default: f3 = 3'b000;
      endcase
      case (kind)
        0, 1: image[i] = r_type(f7, rs2, rs1, f3, rd);
        2, 3: image[i] = i_type(12'($urandom), rs1, 3'b000, rd, cpu_pkg::opcode_op_imm);
        4: image[i] = u_type(20'($urandom), rd);
        5: image[i] = i_type(12'(k * 4), 5'd1, 3'b010, rd, cpu_pkg::opcode_load);
        6: image[i] = s_type(12'(k * 4), rs2, 5'd1);
        7: image[i] = b_type(13'(skip * 4), rs2, rs1, {2'b00, sel[0]});
        default: image[i] = j_type(21'(skip * 4), rd);
      endcase
    end
    image[prog_len - 1] = i_type(12'h001, 5'd0, 3'b000, 5'd0, cpu_pkg::opcode_system);
  endtask

  // Reference model of the RV32I subset, run once ahead of the DUT
  task automatic run_model();
    cpu_pkg::word_t regs [32];
    cpu_pkg::word_t pc, inst, a, b, res, next, addr;
    cpu_pkg::reg_addr_t rd;
    logic stop;
    int steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    ref_mem = image;
    pc = cpu_pkg::reset_vector;
    stop = 1'b0;
    steps = 0;
    while (!stop && steps < prog_len) begin
      inst = ref_mem[pc[12:2]];
      a = regs[inst[19:15]];
      b = regs[inst[24:20]];
      rd = inst[11:7];
      res = '0;
      next = pc + 32'd4;
      case (inst[6:0])
        cpu_pkg::opcode_op: begin
          case (inst[14:12])
            3'b000: res = inst[30] ? a - b : a + b;
            3'b010: res = {31'b0, $signed(a) < $signed(b)};
            3'b100: res = a ^ b;
            3'b110: res = a | b;
            default: res = a & b;
          endcase
        end
        cpu_pkg::opcode_op_imm: res = a + {{20{inst[31]}}, inst[31:20]};
        cpu_pkg::opcode_lui: res = {inst[31:12], 12'h000};
        cpu_pkg::opcode_load: begin
          addr = a + {{20{inst[31]}}, inst[31:20]};
          res = ref_mem[addr[12:2]];
        end
        cpu_pkg::opcode_store: begin
          addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          ref_mem[addr[12:2]] = b;
          exp_st_adr.push_back({addr[31:2], 2'b00});
          exp_st_dat.push_back(b);
          rd = 5'd0;
        end
        cpu_pkg::opcode_branch: begin
          rd = 5'd0;
          if ((a == b) != inst[12]) begin
            next = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
          end
        end
        cpu_pkg::opcode_jal: begin
          res = pc + 32'd4;
          next = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        default: begin
          rd = 5'd0;
          stop = 1'b1;
        end
      endcase
      if (rd != 5'd0) begin
        regs[rd] = res;
      end else begin
        res = '0;
      end
      exp_pc.push_back(pc);
      exp_rd.push_back(rd);
      exp_data.push_back(res);
      pc = next;
      steps++;
    end
  endtask

  // Wishbone slave with 0 to 3 wait states per transfer
  always @(negedge clock) begin
    if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc === 1'b1 && wb_stb === 1'b1) begin
      if (!bus_busy) begin
        bus_busy = 1'b1;
        wait_left = zero_wait ? 0 : $urandom_range(0, 3);
      end
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        bus_busy = 1'b0;
        if (wb_we) begin
          if (stores_seen >= exp_st_adr.size()) begin
            other_errors++;
            $display("Unexpected bus write to %h at %0t", wb_adr, $time);
          end else begin
            check_word(wb_adr, exp_st_adr[stores_seen], "store address");
            check_word(wb_dat_w, exp_st_dat[stores_seen], "store data");
            check_word({28'b0, wb_sel}, 32'h0000_000f, "store select");
          end
          stores_seen++;
          mem[wb_adr[12:2]] = wb_dat_w;
        end
        wb_dat_r = mem[wb_adr[12:2]];
        wb_ack = 1'b1;
      end
    end
  end

  always @(negedge clock) begin
    cycles = cycles + 1;
    if (reset === 1'b1 && wb_cyc !== 1'b0) begin
      other_errors++;
      $display("Bus cycle requested while reset is high at %0t", $time);
    end
    if (pass_active && retire_valid === 1'b1) begin
      if (retired >= exp_pc.size()) begin
        other_errors++;
        $display("Retirement past the end of the program at pc %h", retire_pc);
      end else begin
        if (retired == 0) begin
          check_word(retire_pc, cpu_pkg::reset_vector, "first retired pc");
        end
        check_word(retire_pc, exp_pc[retired], "retire_pc");
        check_reg(retire_rd, exp_rd[retired], "retire_rd");
        check_word(retire_data, exp_data[retired], "retire_data");
      end
      retired++;
    end
    if (pass_active && seen_halt) begin
      if (halted !== 1'b1) begin
        other_errors++;
        $display("halted dropped after EBREAK at %0t", $time);
      end
      if (wb_cyc !== 1'b0) begin
        other_errors++;
        $display("Bus cycle started after the core halted at %0t", $time);
      end
    end
    if (pass_active && halted === 1'b1) begin
      seen_halt = 1'b1;
    end
  end

  task automatic run_pass(input logic no_waits, input logic restart_first);
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = image[i];
    end
    zero_wait = no_waits;
    retired = 0;
    stores_seen = 0;
    seen_halt = 1'b0;
    if (restart_first) begin
      @(negedge clock);
      restart = 1'b1;
      @(negedge clock);
      restart = 1'b0;
      @(posedge reset);
    end
    @(negedge reset);
    pass_active = 1'b1;
    while (halted !== 1'b1) begin
      @(negedge clock);
    end
    // Watch the quiet bus for a while after the halt
    repeat (20) @(negedge clock);
    pass_active = 1'b0;
    if (retired != exp_pc.size()) begin
      other_errors++;
      $display("Core retired %0d instructions, the program has %0d", retired, exp_pc.size());
    end
    if (stores_seen != exp_st_adr.size()) begin
      other_errors++;
      $display("Core wrote %0d words, expected %0d", stores_seen, exp_st_adr.size());
    end
  endtask

  initial begin
    wait (cycle_limit > 0 && cycles >= cycle_limit);
    $display("Run stopped after %0d cycles without finishing the program", cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    wb_ack = 1'b0;
    wb_dat_r = '0;
    restart = 1'b0;
    zero_wait = 1'b1;
    bus_busy = 1'b0;
    wait_left = 0;
    pass_active = 1'b0;
    seen_halt = 1'b0;
    retired = 0;
    stores_seen = 0;
    void'($urandom(32'ha42d));
    make_program();
    run_model();
    cycle_limit = 200 * prog_len * 2;
    run_pass(1'b1, 1'b0);
    run_pass(1'b0, 1'b1);
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cpu.sv ====
`default_nettype none

module cpu (
  input  wire                 clock,
  input  wire                 reset,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output logic [3:0]          wb_sel,
  output cpu_pkg::word_t      wb_adr,
  output cpu_pkg::word_t      wb_dat_w,
  input  wire cpu_pkg::word_t wb_dat_r,
  input  wire                 wb_ack,
  output logic                retire_valid,
  output cpu_pkg::word_t      retire_pc,
  output cpu_pkg::reg_addr_t  retire_rd,
  output cpu_pkg::word_t      retire_data,
  output logic                halted
);

  cpu_pkg::reg_addr_t gpr_raddr1, gpr_raddr2, gpr_waddr;
  cpu_pkg::word_t     gpr_rdata1, gpr_rdata2, gpr_wdata;
  logic               gpr_wen;

  logic ifu_cyc, ifu_stb, ifu_ack;
  cpu_pkg::word_t ifu_adr, ifu_dat_r;
  logic lsu_cyc, lsu_stb, lsu_we, lsu_ack;
  logic [3:0] lsu_sel;
  cpu_pkg::word_t lsu_adr, lsu_dat_w, lsu_dat_r;

  logic           redirect_valid;
  cpu_pkg::word_t redirect_pc;

  logic           ifu_out_valid, idu_in_ready;
  cpu_pkg::word_t ifu_out_pc, ifu_out_inst;

  logic               idu_out_valid, exu_in_ready;
  cpu_pkg::word_t     idu_out_pc, idu_out_val_a, idu_out_val_b, idu_out_imm;
  cpu_pkg::reg_addr_t idu_out_rd;
  cpu_pkg::alu_op_t   idu_out_alu_op;
  cpu_pkg::ls_t       idu_out_ls;
  logic idu_out_is_branch, idu_out_branch_ne, idu_out_is_jal, idu_out_halt;

  logic               exu_out_valid, wbu_in_ready;
  cpu_pkg::word_t     exu_out_pc, exu_out_rd_data, exu_out_next_pc;
  cpu_pkg::reg_addr_t exu_out_rd;
  logic               exu_out_rd_wen, exu_out_halt;

  gpr gpr0 (
    .clock(clock), .reset(reset),
    .raddr1(gpr_raddr1), .raddr2(gpr_raddr2),
    .rdata1(gpr_rdata1), .rdata2(gpr_rdata2),
    .wen(gpr_wen), .waddr(gpr_waddr), .wdata(gpr_wdata)
  );

  ifu ifu0 (
    .clock(clock), .reset(reset),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .wb_cyc(ifu_cyc), .wb_stb(ifu_stb), .wb_adr(ifu_adr),
    .wb_dat_r(ifu_dat_r), .wb_ack(ifu_ack),
    .out_ready(idu_in_ready), .out_valid(ifu_out_valid),
    .out_pc(ifu_out_pc), .out_inst(ifu_out_inst)
  );

  idu idu0 (
    .clock(clock), .reset(reset),
    .in_valid(ifu_out_valid), .in_ready(idu_in_ready),
    .in_pc(ifu_out_pc), .in_inst(ifu_out_inst),
    .rs1(gpr_raddr1), .rs2(gpr_raddr2),
    .src1(gpr_rdata1), .src2(gpr_rdata2),
    .out_ready(exu_in_ready), .out_valid(idu_out_valid),
    .out_pc(idu_out_pc), .out_val_a(idu_out_val_a),
    .out_val_b(idu_out_val_b), .out_imm(idu_out_imm),
    .out_rd(idu_out_rd), .out_alu_op(idu_out_alu_op), .out_ls(idu_out_ls),
    .out_is_branch(idu_out_is_branch), .out_branch_ne(idu_out_branch_ne),
    .out_is_jal(idu_out_is_jal), .out_halt(idu_out_halt)
  );

  exu exu0 (
    .clock(clock), .reset(reset),
    .in_valid(idu_out_valid), .in_ready(exu_in_ready),
    .in_pc(idu_out_pc), .in_val_a(idu_out_val_a),
    .in_val_b(idu_out_val_b), .in_imm(idu_out_imm),
    .in_rd(idu_out_rd), .in_alu_op(idu_out_alu_op), .in_ls(idu_out_ls),
    .in_is_branch(idu_out_is_branch), .in_branch_ne(idu_out_branch_ne),
    .in_is_jal(idu_out_is_jal), .in_halt(idu_out_halt),
    .wb_cyc(lsu_cyc), .wb_stb(lsu_stb), .wb_we(lsu_we), .wb_sel(lsu_sel),
    .wb_adr(lsu_adr), .wb_dat_w(lsu_dat_w),
    .wb_dat_r(lsu_dat_r), .wb_ack(lsu_ack),
    .out_ready(wbu_in_ready), .out_valid(exu_out_valid),
    .out_pc(exu_out_pc), .out_rd(exu_out_rd), .out_rd_wen(exu_out_rd_wen),
    .out_rd_data(exu_out_rd_data), .out_next_pc(exu_out_next_pc),
    .out_halt(exu_out_halt)
  );

  wbu wbu0 (
    .clock(clock), .reset(reset),
    .in_valid(exu_out_valid), .in_ready(wbu_in_ready),
    .in_pc(exu_out_pc), .in_rd(exu_out_rd), .in_rd_wen(exu_out_rd_wen),
    .in_rd_data(exu_out_rd_data), .in_next_pc(exu_out_next_pc),
    .in_halt(exu_out_halt),
    .gpr_wen(gpr_wen), .gpr_waddr(gpr_waddr), .gpr_wdata(gpr_wdata),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .retire_valid(retire_valid), .retire_pc(retire_pc),
    .retire_rd(retire_rd), .retire_data(retire_data),
    .halted(halted)
  );

  // Fetch only reads whole words, so its write side is tied off
  mem_arb mem_arb0 (
    .clock(clock), .reset(reset),
    .ifu_cyc(ifu_cyc), .ifu_stb(ifu_stb), .ifu_we(1'b0), .ifu_sel(4'b1111),
    .ifu_adr(ifu_adr), .ifu_dat_w(32'h0000_0000),
    .ifu_dat_r(ifu_dat_r), .ifu_ack(ifu_ack),
    .lsu_cyc(lsu_cyc), .lsu_stb(lsu_stb), .lsu_we(lsu_we), .lsu_sel(lsu_sel),
    .lsu_adr(lsu_adr), .lsu_dat_w(lsu_dat_w),
    .lsu_dat_r(lsu_dat_r), .lsu_ack(lsu_ack),
    .bus_cyc(wb_cyc), .bus_stb(wb_stb), .bus_we(wb_we), .bus_sel(wb_sel),
    .bus_adr(wb_adr), .bus_dat_w(wb_dat_w),
    .bus_dat_r(wb_dat_r), .bus_ack(wb_ack)
  );

endmodule

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {
    ls_none,
    ls_load,
    ls_store
  } ls_t;

  // Major opcodes of the supported RV32I subset
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // First instruction fetched after reset
  localparam word_t reset_vector = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== verilog/exu.sv ====
`default_nettype none

module exu (
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     in_valid,
  output logic                    in_ready,
  input  wire cpu_pkg::word_t     in_pc,
  input  wire cpu_pkg::word_t     in_val_a,
  input  wire cpu_pkg::word_t     in_val_b,
  input  wire cpu_pkg::word_t     in_imm,
  input  wire cpu_pkg::reg_addr_t in_rd,
  input  wire cpu_pkg::alu_op_t   in_alu_op,
  input  wire cpu_pkg::ls_t       in_ls,
  input  wire                     in_is_branch,
  input  wire                     in_branch_ne,
  input  wire                     in_is_jal,
  input  wire                     in_halt,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output logic                    wb_we,
  output logic [3:0]              wb_sel,
  output cpu_pkg::word_t          wb_adr,
  output cpu_pkg::word_t          wb_dat_w,
  input  wire cpu_pkg::word_t     wb_dat_r,
  input  wire                     wb_ack,
  input  wire                     out_ready,
  output logic                    out_valid,
  output cpu_pkg::word_t          out_pc,
  output cpu_pkg::reg_addr_t      out_rd,
  output logic                    out_rd_wen,
  output cpu_pkg::word_t          out_rd_data,
  output cpu_pkg::word_t          out_next_pc,
  output logic                    out_halt
);

  cpu_pkg::word_t alu_result;
  cpu_pkg::word_t eff_addr;
  cpu_pkg::word_t seq_pc;
  logic accept, taken, mem_done;

  assign in_ready = !out_valid && !wb_cyc;
  assign accept   = in_valid && in_ready;
  assign mem_done = wb_cyc && wb_ack;
  assign wb_stb   = wb_cyc;
  assign wb_sel   = 4'b1111;

  assign eff_addr = in_val_a + in_imm;
  assign seq_pc   = in_pc + 32'd4;
  assign taken    = in_is_jal || (in_is_branch && ((in_val_a == in_val_b) != in_branch_ne));

  always_comb begin
    case (in_alu_op)
      cpu_pkg::alu_sub: alu_result = in_val_a - in_val_b;
      cpu_pkg::alu_and: alu_result = in_val_a & in_val_b;
      cpu_pkg::alu_or:  alu_result = in_val_a | in_val_b;
      cpu_pkg::alu_xor: alu_result = in_val_a ^ in_val_b;
      cpu_pkg::alu_slt: alu_result = {31'b0, $signed(in_val_a) < $signed(in_val_b)};
      cpu_pkg::alu_pass_b: alu_result = in_val_b;
      default: alu_result = in_val_a + in_val_b;
    endcase
  end

  // Memory operations hold the result back until the bus acknowledges
  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
      wb_cyc    <= 1'b0;
    end else if (accept) begin
      wb_cyc    <= (in_ls != cpu_pkg::ls_none);
      out_valid <= (in_ls == cpu_pkg::ls_none);
    end else if (mem_done) begin
      wb_cyc    <= 1'b0;
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      out_pc      <= in_pc;
      out_rd      <= in_rd;
      out_rd_wen  <= (in_rd != 5'd0);
      out_rd_data <= (in_rd == 5'd0) ? '0 : (in_is_jal ? seq_pc : alu_result);
      out_next_pc <= taken ? in_pc + in_imm : seq_pc;
      out_halt    <= in_halt;
      wb_we       <= (in_ls == cpu_pkg::ls_store);
      wb_adr      <= {eff_addr[31:2], 2'b00};
      wb_dat_w    <= in_val_b;
    end else if (mem_done && !wb_we && out_rd_wen) begin
      out_rd_data <= wb_dat_r;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/gpr.sv ====
`default_nettype none

module gpr (
  input  wire                    clock,
  input  wire                    reset,
  input  wire cpu_pkg::reg_addr_t raddr1,
  input  wire cpu_pkg::reg_addr_t raddr2,
  output cpu_pkg::word_t         rdata1,
  output cpu_pkg::word_t         rdata2,
  input  wire                    wen,
  input  wire cpu_pkg::reg_addr_t waddr,
  input  wire cpu_pkg::word_t    wdata
);

  cpu_pkg::word_t regs [32];

  // x0 is cleared by reset and never written, so it always reads zero
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/idu.sv ====
`default_nettype none

module idu (
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     in_valid,
  output logic                    in_ready,
  input  wire cpu_pkg::word_t     in_pc,
  input  wire cpu_pkg::word_t     in_inst,
  output cpu_pkg::reg_addr_t      rs1,
  output cpu_pkg::reg_addr_t      rs2,
  input  wire cpu_pkg::word_t     src1,
  input  wire cpu_pkg::word_t     src2,
  input  wire                     out_ready,
  output logic                    out_valid,
  output cpu_pkg::word_t          out_pc,
  output cpu_pkg::word_t          out_val_a,
  output cpu_pkg::word_t          out_val_b,
  output cpu_pkg::word_t          out_imm,
  output cpu_pkg::reg_addr_t      out_rd,
  output cpu_pkg::alu_op_t        out_alu_op,
  output cpu_pkg::ls_t            out_ls,
  output logic                    out_is_branch,
  output logic                    out_branch_ne,
  output logic                    out_is_jal,
  output logic                    out_halt
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  cpu_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  cpu_pkg::word_t     d_imm;
  cpu_pkg::word_t     d_val_b;
  cpu_pkg::reg_addr_t d_rd;
  cpu_pkg::alu_op_t   d_alu_op;
  cpu_pkg::ls_t       d_ls;
  logic d_branch, d_ne, d_jal, d_halt;

  assign opcode = in_inst[6:0];
  assign funct3 = in_inst[14:12];
  assign funct7 = in_inst[31:25];
  assign rs1    = in_inst[19:15];
  assign rs2    = in_inst[24:20];

  assign imm_i = {{20{in_inst[31]}}, in_inst[31:20]};
  assign imm_s = {{20{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
  assign imm_b = {{19{in_inst[31]}}, in_inst[31], in_inst[7], in_inst[30:25],
                  in_inst[11:8], 1'b0};
  assign imm_u = {in_inst[31:12], 12'b0};
  assign imm_j = {{11{in_inst[31]}}, in_inst[31], in_inst[19:12], in_inst[20],
                  in_inst[30:21], 1'b0};

  // The output buffer holds one instruction, and only one is ever in flight
  assign in_ready = !out_valid;

  always_comb begin
    d_imm    = imm_i;
    d_val_b  = src2;
    d_rd     = in_inst[11:7];
    d_alu_op = cpu_pkg::alu_add;
    d_ls     = cpu_pkg::ls_none;
    d_branch = 1'b0;
    d_ne     = 1'b0;
    d_jal    = 1'b0;
    d_halt   = 1'b0;
    case (opcode)
      cpu_pkg::opcode_op: begin
        case (funct3)
          3'b000:  d_alu_op = funct7[5] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
          3'b010:  d_alu_op = cpu_pkg::alu_slt;
          3'b100:  d_alu_op = cpu_pkg::alu_xor;
          3'b110:  d_alu_op = cpu_pkg::alu_or;
          3'b111:  d_alu_op = cpu_pkg::alu_and;
          default: d_halt = 1'b1;
        endcase
        if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
          d_halt = 1'b1;
        end
      end
      cpu_pkg::opcode_op_imm: begin
        d_val_b = imm_i;
        d_halt  = (funct3 != 3'b000);
      end
      cpu_pkg::opcode_lui: begin
        d_imm    = imm_u;
        d_val_b  = imm_u;
        d_alu_op = cpu_pkg::alu_pass_b;
      end
      cpu_pkg::opcode_load: begin
        d_ls   = cpu_pkg::ls_load;
        d_halt = (funct3 != 3'b010);
      end
      cpu_pkg::opcode_store: begin
        d_imm  = imm_s;
        d_rd   = 5'd0;
        d_ls   = cpu_pkg::ls_store;
        d_halt = (funct3 != 3'b010);
      end
      cpu_pkg::opcode_branch: begin
        d_imm    = imm_b;
        d_rd     = 5'd0;
        d_branch = 1'b1;
        d_ne     = funct3[0];
        d_halt   = (funct3[2:1] != 2'b00);
      end
      cpu_pkg::opcode_jal: begin
        d_imm = imm_j;
        d_jal = 1'b1;
      end
      // EBREAK and every other SYSTEM or unknown encoding stop the core
      default: d_halt = 1'b1;
    endcase
    if (d_halt) begin
      d_rd     = 5'd0;
      d_ls     = cpu_pkg::ls_none;
      d_branch = 1'b0;
      d_jal    = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      out_pc        <= in_pc;
      out_val_a     <= src1;
      out_val_b     <= d_val_b;
      out_imm       <= d_imm;
      out_rd        <= d_rd;
      out_alu_op    <= d_alu_op;
      out_ls        <= d_ls;
      out_is_branch <= d_branch;
      out_branch_ne <= d_ne;
      out_is_jal    <= d_jal;
      out_halt      <= d_halt;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ifu.sv ====
`default_nettype none

module ifu (
  input  wire                 clock,
  input  wire                 reset,
  input  wire                 redirect_valid,
  input  wire cpu_pkg::word_t redirect_pc,
  output logic                wb_cyc,
  output logic                wb_stb,
  output cpu_pkg::word_t      wb_adr,
  input  wire cpu_pkg::word_t wb_dat_r,
  input  wire                 wb_ack,
  input  wire                 out_ready,
  output logic                out_valid,
  output cpu_pkg::word_t      out_pc,
  output cpu_pkg::word_t      out_inst
);

  typedef enum logic [1:0] {
    st_fetch,
    st_hand_over,
    st_wait_retire
  } fetch_state_t;

  fetch_state_t   state;
  cpu_pkg::word_t pc;
  cpu_pkg::word_t inst;

  assign wb_stb    = wb_cyc;
  assign wb_adr    = pc;
  assign out_valid = (state == st_hand_over);
  assign out_pc    = pc;
  assign out_inst  = inst;

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= st_fetch;
      pc     <= cpu_pkg::reset_vector;
      wb_cyc <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          // The bus request is only idle here in the first cycle out of reset
          if (!wb_cyc) begin
            wb_cyc <= 1'b1;
          end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            state  <= st_hand_over;
          end
        end
        st_hand_over: begin
          if (out_ready) begin
            state <= st_wait_retire;
          end
        end
        default: begin
          // Stays here for good once writeback has halted the core
          if (redirect_valid) begin
            pc     <= redirect_pc;
            wb_cyc <= 1'b1;
            state  <= st_fetch;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_fetch && wb_cyc && wb_ack) begin
      inst <= wb_dat_r;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_arb.sv ====
`default_nettype none

module mem_arb (
  input  wire                 clock,
  input  wire                 reset,
  input  wire                 ifu_cyc,
  input  wire                 ifu_stb,
  input  wire                 ifu_we,
  input  wire [3:0]           ifu_sel,
  input  wire cpu_pkg::word_t ifu_adr,
  input  wire cpu_pkg::word_t ifu_dat_w,
  output cpu_pkg::word_t      ifu_dat_r,
  output logic                ifu_ack,
  input  wire                 lsu_cyc,
  input  wire                 lsu_stb,
  input  wire                 lsu_we,
  input  wire [3:0]           lsu_sel,
  input  wire cpu_pkg::word_t lsu_adr,
  input  wire cpu_pkg::word_t lsu_dat_w,
  output cpu_pkg::word_t      lsu_dat_r,
  output logic                lsu_ack,
  output logic                bus_cyc,
  output logic                bus_stb,
  output logic                bus_we,
  output logic [3:0]          bus_sel,
  output cpu_pkg::word_t      bus_adr,
  output cpu_pkg::word_t      bus_dat_w,
  input  wire cpu_pkg::word_t bus_dat_r,
  input  wire                 bus_ack
);

  logic locked;
  logic owner_lsu;
  logic pick_lsu;

  // While idle the load/store side wins, after that the owner keeps the bus
  assign pick_lsu = locked ? owner_lsu : lsu_cyc;

  assign bus_cyc   = pick_lsu ? lsu_cyc   : ifu_cyc;
  assign bus_stb   = pick_lsu ? lsu_stb   : ifu_stb;
  assign bus_we    = pick_lsu ? lsu_we    : ifu_we;
  assign bus_sel   = pick_lsu ? lsu_sel   : ifu_sel;
  assign bus_adr   = pick_lsu ? lsu_adr   : ifu_adr;
  assign bus_dat_w = pick_lsu ? lsu_dat_w : ifu_dat_w;

  assign ifu_ack   = bus_ack && !pick_lsu;
  assign lsu_ack   = bus_ack && pick_lsu;
  assign ifu_dat_r = bus_dat_r;
  assign lsu_dat_r = bus_dat_r;

  always_ff @(posedge clock) begin
    if (reset) begin
      locked    <= 1'b0;
      owner_lsu <= 1'b0;
    end else begin
      locked <= bus_cyc;
      if (!locked) begin
        owner_lsu <= pick_lsu;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wbu.sv ====
`default_nettype none

module wbu (
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     in_valid,
  output logic                    in_ready,
  input  wire cpu_pkg::word_t     in_pc,
  input  wire cpu_pkg::reg_addr_t in_rd,
  input  wire                     in_rd_wen,
  input  wire cpu_pkg::word_t     in_rd_data,
  input  wire cpu_pkg::word_t     in_next_pc,
  input  wire                     in_halt,
  output logic                    gpr_wen,
  output cpu_pkg::reg_addr_t      gpr_waddr,
  output cpu_pkg::word_t          gpr_wdata,
  output logic                    redirect_valid,
  output cpu_pkg::word_t          redirect_pc,
  output logic                    retire_valid,
  output cpu_pkg::word_t          retire_pc,
  output cpu_pkg::reg_addr_t      retire_rd,
  output cpu_pkg::word_t          retire_data,
  output logic                    halted
);

  logic accept;

  assign in_ready  = !halted;
  assign accept    = in_valid && in_ready;
  assign gpr_wen   = accept && in_rd_wen;
  assign gpr_waddr = in_rd;
  assign gpr_wdata = in_rd_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid   <= 1'b0;
      redirect_valid <= 1'b0;
      halted         <= 1'b0;
    end else begin
      retire_valid   <= accept;
      // A halting instruction retires but never restarts fetch
      redirect_valid <= accept && !in_halt;
      if (accept && in_halt) begin
        halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      retire_pc   <= in_pc;
      retire_rd   <= in_rd;
      retire_data <= in_rd_data;
      redirect_pc <= in_next_pc;
    end
  end

endmodule

`default_nettype wire
